// ==== verilog/clock_pkg.sv ====
package clock_pkg;

    typedef logic [3:0]  bcd_digit_t;
    typedef logic [6:0]  seg_code_t;    // active low, bit 0 is segment a
    typedef logic [15:0] keypad_t;      // one-hot, bits 0 to 9 are the digits

    typedef enum logic [1:0] {
        SHOW_TIME,
        SHOW_ALARM,
        SHOW_TIMER,
        SHOW_ENTRY
    } disp_mode_t;

    typedef enum logic [1:0] {
        ENTRY_IDLE,
        ENTRY_TYPING,
        ENTRY_READY
    } entry_state_t;

    // command keys
    localparam int KEY_TIMER    = 10;
    localparam int KEY_TIME_SET = 11;
    localparam int KEY_ALARM    = 12;

    // idle cycles a complete entry waits for a command
    localparam int ENTRY_HOLD_CYCLES = 5;

    // power-up time 11:50
    localparam bcd_digit_t RESET_HOUR_TENS  = 4'd1;
    localparam bcd_digit_t RESET_HOUR_UNITS = 4'd1;
    localparam bcd_digit_t RESET_MIN_TENS   = 4'd5;
    localparam bcd_digit_t RESET_MIN_UNITS  = 4'd0;

    localparam bcd_digit_t DIGIT_BLANK = 4'd15;  // untyped entry digit
    localparam seg_code_t  SEG_BLANK   = 7'b1111111;

endpackage

// ==== verilog/timekeeper.sv ====
`timescale 1ns/1ns

module timekeeper import clock_pkg::*; (
    input  logic       CLK_60s,
    input  logic       reset,
    input  logic       time_load,
    input  logic       alarm_load,
    input  bcd_digit_t entry_hour_tens,
    input  bcd_digit_t entry_hour_units,
    input  bcd_digit_t entry_min_tens,
    input  bcd_digit_t entry_min_units,
    output bcd_digit_t time_hour_tens,
    output bcd_digit_t time_hour_units,
    output bcd_digit_t time_min_tens,
    output bcd_digit_t time_min_units,
    output bcd_digit_t alarm_hour_tens,
    output bcd_digit_t alarm_hour_units,
    output bcd_digit_t alarm_min_tens,
    output bcd_digit_t alarm_min_units,
    output logic       beep_alarm
);

    logic alarm_valid;
    logic hour_carry;
    logic day_wrap;
    logic alarm_match;

    assign hour_carry  = (time_min_units == 4'd9) && (time_min_tens == 4'd5);
    assign day_wrap    = (time_hour_tens == 4'd2) && (time_hour_units == 4'd3);
    assign alarm_match = {time_hour_tens, time_hour_units, time_min_tens, time_min_units} ==
                         {alarm_hour_tens, alarm_hour_units, alarm_min_tens, alarm_min_units};

    // one minute per clock
    always_ff @(posedge CLK_60s) begin
        if (!reset) begin
            time_hour_tens  <= RESET_HOUR_TENS;
            time_hour_units <= RESET_HOUR_UNITS;
            time_min_tens   <= RESET_MIN_TENS;
            time_min_units  <= RESET_MIN_UNITS;
        end else if (time_load) begin
            time_hour_tens  <= entry_hour_tens;
            time_hour_units <= entry_hour_units;
            time_min_tens   <= entry_min_tens;
            time_min_units  <= entry_min_units;
        end else begin
            time_min_units <= (time_min_units == 4'd9) ? 4'd0 : time_min_units + 4'd1;
            if (time_min_units == 4'd9)
                time_min_tens <= (time_min_tens == 4'd5) ? 4'd0 : time_min_tens + 4'd1;
            if (hour_carry) begin
                if (day_wrap) begin                 // 23:59 -> 00:00
                    time_hour_tens  <= 4'd0;
                    time_hour_units <= 4'd0;
                end else if (time_hour_units == 4'd9) begin
                    time_hour_tens  <= time_hour_tens + 4'd1;
                    time_hour_units <= 4'd0;
                end else begin
                    time_hour_units <= time_hour_units + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge CLK_60s) begin
        if (alarm_load) begin
            alarm_hour_tens  <= entry_hour_tens;
            alarm_hour_units <= entry_hour_units;
            alarm_min_tens   <= entry_min_tens;
            alarm_min_units  <= entry_min_units;
        end
    end

    always_ff @(posedge CLK_60s) begin
        if (!reset) begin
            alarm_valid <= 1'b0;
            beep_alarm  <= 1'b0;
        end else begin
            if (alarm_load)
                alarm_valid <= 1'b1;
            beep_alarm <= alarm_valid && alarm_match;
        end
    end

    // entries come unchecked from the keypad, so a bad time set shows up here
    a_min_tens: assert property (@(posedge CLK_60s) disable iff (!reset)
        time_min_tens <= 4'd5);
    a_hours: assert property (@(posedge CLK_60s) disable iff (!reset)
        (time_hour_tens < 4'd2) || ((time_hour_tens == 4'd2) && (time_hour_units <= 4'd3)));

endmodule

// ==== verilog/keypad_control.sv ====
`timescale 1ns/1ns

module keypad_control import clock_pkg::*; (
    input  logic       CLK_60s,
    input  logic       reset,
    input  keypad_t    btn,
    input  logic       timer_running,
    input  logic       timer_done,
    output bcd_digit_t entry_hour_tens,
    output bcd_digit_t entry_hour_units,
    output bcd_digit_t entry_min_tens,
    output bcd_digit_t entry_min_units,
    output logic       time_load,
    output logic       alarm_load,
    output logic       timer_start,
    output disp_mode_t disp_mode
);

    keypad_t      btn_prev;
    entry_state_t entry_state;
    logic [1:0]   digit_cnt;        // next entry position
    logic [2:0]   hold_cnt;
    logic         press;
    logic         digit_press;
    logic         cmd_press;
    bcd_digit_t   key_digit;

    // new single key after all released
    assign press       = (btn_prev == '0) && (btn != '0) && ((btn & (btn - 16'd1)) == '0);
    assign digit_press = press && (btn[9:0] != '0);
    assign cmd_press   = press && (btn[KEY_TIME_SET] || btn[KEY_ALARM] || btn[KEY_TIMER]);

    always_comb begin
        key_digit = '0;
        for (int i = 0; i < 10; i++) begin
            if (btn[i])
                key_digit = bcd_digit_t'(i);
        end
    end

    always_ff @(posedge CLK_60s) begin
        if (!reset) begin
            btn_prev    <= '0;
            entry_state <= ENTRY_IDLE;
            digit_cnt   <= '0;
            hold_cnt    <= '0;
            time_load   <= 1'b0;
            alarm_load  <= 1'b0;
            timer_start <= 1'b0;
        end else begin
            btn_prev    <= btn;
            time_load   <= 1'b0;
            alarm_load  <= 1'b0;
            timer_start <= 1'b0;
            case (entry_state)
                ENTRY_IDLE: begin
                    if (digit_press) begin
                        entry_state <= ENTRY_TYPING;
                        digit_cnt   <= 2'd1;
                    end
                end
                ENTRY_TYPING: begin
                    if (digit_press) begin
                        digit_cnt <= digit_cnt + 2'd1;
                        if (digit_cnt == 2'd3) begin
                            entry_state <= ENTRY_READY;
                            hold_cnt    <= '0;
                        end
                    end
                end
                ENTRY_READY: begin
                    if (cmd_press) begin
                        time_load   <= btn[KEY_TIME_SET];
                        alarm_load  <= btn[KEY_ALARM];
                        timer_start <= btn[KEY_TIMER];
                        entry_state <= ENTRY_IDLE;
                    end else if (press) begin
                        hold_cnt <= '0;                 // any other key restarts the wait
                    end else if (hold_cnt == 3'(ENTRY_HOLD_CYCLES - 1)) begin
                        entry_state <= ENTRY_IDLE;      // abandoned
                    end else begin
                        hold_cnt <= hold_cnt + 3'd1;
                    end
                end
                default: entry_state <= ENTRY_IDLE;
            endcase
        end
    end

    // digits stay put after a command so the load sees them
    always_ff @(posedge CLK_60s) begin
        if (digit_press) begin
            if (entry_state == ENTRY_IDLE) begin
                entry_hour_tens  <= key_digit;
                entry_hour_units <= DIGIT_BLANK;
                entry_min_tens   <= DIGIT_BLANK;
                entry_min_units  <= DIGIT_BLANK;
            end else if (entry_state == ENTRY_TYPING) begin
                case (digit_cnt)
                    2'd1: entry_hour_units <= key_digit;
                    2'd2: entry_min_tens   <= key_digit;
                    2'd3: entry_min_units  <= key_digit;
                    default: entry_hour_tens <= key_digit;
                endcase
            end
        end
    end

    always_comb begin
        if (entry_state != ENTRY_IDLE)
            disp_mode = SHOW_ENTRY;
        else if (btn[KEY_ALARM])
            disp_mode = SHOW_ALARM;
        else if (timer_running || timer_done)   // 00:00 stays up for the end beep
            disp_mode = SHOW_TIMER;
        else
            disp_mode = SHOW_TIME;
    end

    a_one_strobe: assert property (@(posedge CLK_60s) disable iff (!reset)
        $onehot0({time_load, alarm_load, timer_start}));

endmodule

// ==== verilog/countdown_timer.sv ====
`timescale 1ns/1ns

module countdown_timer import clock_pkg::*; (
    input  logic       CLK_60s,
    input  logic       reset,
    input  logic       timer_start,
    input  bcd_digit_t entry_hour_tens,
    input  bcd_digit_t entry_hour_units,
    input  bcd_digit_t entry_min_tens,
    input  bcd_digit_t entry_min_units,
    output bcd_digit_t timer_hour_tens,
    output bcd_digit_t timer_hour_units,
    output bcd_digit_t timer_min_tens,
    output bcd_digit_t timer_min_units,
    output logic       timer_running,
    output logic       timer_done
);

    logic count_zero;
    logic count_last;

    assign count_zero = {timer_hour_tens, timer_hour_units, timer_min_tens, timer_min_units} ==
                        16'h0000;
    assign count_last = {timer_hour_tens, timer_hour_units, timer_min_tens, timer_min_units} ==
                        16'h0001;

    always_ff @(posedge CLK_60s) begin
        if (!reset) begin
            timer_running <= 1'b0;
            timer_done    <= 1'b0;
        end else if (timer_start) begin
            timer_running <= 1'b1;
            timer_done    <= 1'b0;
        end else if (timer_running && (count_zero || count_last)) begin
            timer_running <= 1'b0;      // lands on 00:00 now
            timer_done    <= 1'b1;
        end else begin
            timer_done <= 1'b0;
        end
    end

    always_ff @(posedge CLK_60s) begin
        if (timer_start) begin
            timer_hour_tens  <= entry_hour_tens;
            timer_hour_units <= entry_hour_units;
            timer_min_tens   <= entry_min_tens;
            timer_min_units  <= entry_min_units;
        end else if (timer_running && !count_zero) begin
            timer_min_units <= (timer_min_units == 4'd0) ? 4'd9 : timer_min_units - 4'd1;
            if (timer_min_units == 4'd0)
                timer_min_tens <= (timer_min_tens == 4'd0) ? 4'd5 : timer_min_tens - 4'd1;
            if (timer_min_units == 4'd0 && timer_min_tens == 4'd0) begin
                // borrow from the hours
                timer_hour_units <= (timer_hour_units == 4'd0) ? 4'd9 : timer_hour_units - 4'd1;
                if (timer_hour_units == 4'd0)
                    timer_hour_tens <= timer_hour_tens - 4'd1;
            end
        end
    end

    a_done_pulse: assert property (@(posedge CLK_60s) disable iff (!reset)
        timer_done |=> !timer_done);

endmodule

// ==== verilog/display_driver.sv ====
`timescale 1ns/1ns

module display_driver import clock_pkg::*; (
    input  disp_mode_t disp_mode,
    input  bcd_digit_t time_hour_tens,
    input  bcd_digit_t time_hour_units,
    input  bcd_digit_t time_min_tens,
    input  bcd_digit_t time_min_units,
    input  bcd_digit_t alarm_hour_tens,
    input  bcd_digit_t alarm_hour_units,
    input  bcd_digit_t alarm_min_tens,
    input  bcd_digit_t alarm_min_units,
    input  bcd_digit_t timer_hour_tens,
    input  bcd_digit_t timer_hour_units,
    input  bcd_digit_t timer_min_tens,
    input  bcd_digit_t timer_min_units,
    input  bcd_digit_t entry_hour_tens,
    input  bcd_digit_t entry_hour_units,
    input  bcd_digit_t entry_min_tens,
    input  bcd_digit_t entry_min_units,
    output seg_code_t  seg_hour_tens,
    output seg_code_t  seg_hour_units,
    output seg_code_t  seg_min_tens,
    output seg_code_t  seg_min_units
);

    bcd_digit_t show_hour_tens, show_hour_units, show_min_tens, show_min_units;

    // gfedcba, low lights the segment
    function automatic seg_code_t seg_decode(input bcd_digit_t digit);
        case (digit)
            4'd0: return 7'b1000000;
            4'd1: return 7'b1111001;
            4'd2: return 7'b0100100;
            4'd3: return 7'b0110000;
            4'd4: return 7'b0011001;
            4'd5: return 7'b0010010;
            4'd6: return 7'b0000010;
            4'd7: return 7'b1111000;
            4'd8: return 7'b0000000;
            4'd9: return 7'b0010000;
            default: return SEG_BLANK;
        endcase
    endfunction

    always_comb begin
        case (disp_mode)
            SHOW_ALARM: begin
                show_hour_tens  = alarm_hour_tens;
                show_hour_units = alarm_hour_units;
                show_min_tens   = alarm_min_tens;
                show_min_units  = alarm_min_units;
            end
            SHOW_TIMER: begin
                show_hour_tens  = timer_hour_tens;
                show_hour_units = timer_hour_units;
                show_min_tens   = timer_min_tens;
                show_min_units  = timer_min_units;
            end
            SHOW_ENTRY: begin
                show_hour_tens  = entry_hour_tens;
                show_hour_units = entry_hour_units;
                show_min_tens   = entry_min_tens;
                show_min_units  = entry_min_units;
            end
            default: begin
                show_hour_tens  = time_hour_tens;
                show_hour_units = time_hour_units;
                show_min_tens   = time_min_tens;
                show_min_units  = time_min_units;
            end
        endcase
    end

    assign seg_hour_tens  = seg_decode(show_hour_tens);
    assign seg_hour_units = seg_decode(show_hour_units);
    assign seg_min_tens   = seg_decode(show_min_tens);
    assign seg_min_units  = seg_decode(show_min_units);

endmodule

// ==== verilog/alarm_clock_top.sv ====
`timescale 1ns/1ns

module alarm_clock_top import clock_pkg::*; (
    input  logic      CLK_60s,
    input  logic      reset,
    input  keypad_t   btn,
    output seg_code_t seg_hour_tens,
    output seg_code_t seg_hour_units,
    output seg_code_t seg_min_tens,
    output seg_code_t seg_min_units,
    output logic      beep_alarm,
    output logic      beep_timer
);

    bcd_digit_t entry_hour_tens, entry_hour_units, entry_min_tens, entry_min_units;
    bcd_digit_t time_hour_tens, time_hour_units, time_min_tens, time_min_units;
    bcd_digit_t alarm_hour_tens, alarm_hour_units, alarm_min_tens, alarm_min_units;
    bcd_digit_t timer_hour_tens, timer_hour_units, timer_min_tens, timer_min_units;
    logic       time_load;
    logic       alarm_load;
    logic       timer_start;
    logic       timer_running;
    disp_mode_t disp_mode;

    keypad_control u_keypad (
        .CLK_60s          (CLK_60s),
        .reset            (reset),
        .btn              (btn),
        .timer_running    (timer_running),
        .timer_done       (beep_timer),      // end pulse doubles as the beep
        .entry_hour_tens  (entry_hour_tens),
        .entry_hour_units (entry_hour_units),
        .entry_min_tens   (entry_min_tens),
        .entry_min_units  (entry_min_units),
        .time_load        (time_load),
        .alarm_load       (alarm_load),
        .timer_start      (timer_start),
        .disp_mode        (disp_mode)
    );

    timekeeper u_timekeeper (
        .CLK_60s          (CLK_60s),
        .reset            (reset),
        .time_load        (time_load),
        .alarm_load       (alarm_load),
        .entry_hour_tens  (entry_hour_tens),
        .entry_hour_units (entry_hour_units),
        .entry_min_tens   (entry_min_tens),
        .entry_min_units  (entry_min_units),
        .time_hour_tens   (time_hour_tens),
        .time_hour_units  (time_hour_units),
        .time_min_tens    (time_min_tens),
        .time_min_units   (time_min_units),
        .alarm_hour_tens  (alarm_hour_tens),
        .alarm_hour_units (alarm_hour_units),
        .alarm_min_tens   (alarm_min_tens),
        .alarm_min_units  (alarm_min_units),
        .beep_alarm       (beep_alarm)
    );

    countdown_timer u_timer (
        .CLK_60s          (CLK_60s),
        .reset            (reset),
        .timer_start      (timer_start),
        .entry_hour_tens  (entry_hour_tens),
        .entry_hour_units (entry_hour_units),
        .entry_min_tens   (entry_min_tens),
        .entry_min_units  (entry_min_units),
        .timer_hour_tens  (timer_hour_tens),
        .timer_hour_units (timer_hour_units),
        .timer_min_tens   (timer_min_tens),
        .timer_min_units  (timer_min_units),
        .timer_running    (timer_running),
        .timer_done       (beep_timer)
    );

    display_driver u_display (
        .disp_mode        (disp_mode),
        .time_hour_tens   (time_hour_tens),
        .time_hour_units  (time_hour_units),
        .time_min_tens    (time_min_tens),
        .time_min_units   (time_min_units),
        .alarm_hour_tens  (alarm_hour_tens),
        .alarm_hour_units (alarm_hour_units),
        .alarm_min_tens   (alarm_min_tens),
        .alarm_min_units  (alarm_min_units),
        .timer_hour_tens  (timer_hour_tens),
        .timer_hour_units (timer_hour_units),
        .timer_min_tens   (timer_min_tens),
        .timer_min_units  (timer_min_units),
        .entry_hour_tens  (entry_hour_tens),
        .entry_hour_units (entry_hour_units),
        .entry_min_tens   (entry_min_tens),
        .entry_min_units  (entry_min_units),
        .seg_hour_tens    (seg_hour_tens),
        .seg_hour_units   (seg_hour_units),
        .seg_min_tens     (seg_min_tens),
        .seg_min_units    (seg_min_units)
    );

endmodule

// ==== bench/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1, new bit enters at bit 0
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// segments a..g lit high, then inverted for the active low outputs
function automatic seg_code_t seg_ref(input int digit);
    seg_code_t lit;
    case (digit)
        0: lit = 7'h3f;
        1: lit = 7'h06;
        2: lit = 7'h5b;
        3: lit = 7'h4f;
        4: lit = 7'h66;
        5: lit = 7'h6d;
        6: lit = 7'h7d;
        7: lit = 7'h07;
        8: lit = 7'h7f;
        9: lit = 7'h6f;
        default: lit = 7'h00;   // blank
    endcase
    return ~lit;
endfunction

function automatic logic [27:0] digits_to_segs(input int ht, input int hu,
                                               input int mt, input int mu);
    return {seg_ref(ht), seg_ref(hu), seg_ref(mt), seg_ref(mu)};
endfunction

// minutes since midnight to the four displayed digits
function automatic logic [27:0] minutes_to_segs(input int m);
    int hours;
    int mins;
    hours = m / 60;
    mins  = m % 60;
    return digits_to_segs(hours / 10, hours % 10, mins / 10, mins % 10);
endfunction

function automatic int minute_step(input int m);
    return (m + 1) % (24 * 60);
endfunction

task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
endtask

`endif

// ==== bench/alarm_clock_tb.sv ====
`timescale 1ns/1ns

module alarm_clock_tb import clock_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 4;
    localparam int DAY_MINUTES   = 24 * 60;
    localparam int START_MINUTES = 11 * 60 + 50;
    localparam int WRAP_CYCLES   = DAY_MINUTES - START_MINUTES;  // 11:50 round to 00:00
    localparam int ENTRY_HOLD    = 5;
    localparam int TIMER_MINUTES = 7;
    localparam int ALARM_WAIT    = 64;
    // the wrap run plus a generous allowance for each of the five tests
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + WRAP_CYCLES + 5 * 100;

    logic        CLK_60s = 1'b0;
    logic        reset;
    keypad_t     btn;
    seg_code_t   seg_hour_tens, seg_hour_units, seg_min_tens, seg_min_units;
    logic        beep_alarm;
    logic        beep_timer;
    logic [27:0] seg_all;

    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          cycle = 0;            // rising edges so far
    int          model_minutes = START_MINUTES;
    int          alarm_minutes = 0;
    bit          alarm_valid_model = 1'b0;
    int          press_cycle;
    int          time_load_edge;
    int          time_load_value;
    int          alarm_load_edge;
    int          alarm_load_value;
    int          timer_done_edge;
    bit          time_shown;           // display should follow the model time
    logic [31:0] lfsr_state;

    `include "tb_model.svh"

    alarm_clock_top UUT (
        .CLK_60s        (CLK_60s),
        .reset          (reset),
        .btn            (btn),
        .seg_hour_tens  (seg_hour_tens),
        .seg_hour_units (seg_hour_units),
        .seg_min_tens   (seg_min_tens),
        .seg_min_units  (seg_min_units),
        .beep_alarm     (beep_alarm),
        .beep_timer     (beep_timer)
    );

    assign seg_all = {seg_hour_tens, seg_hour_units, seg_min_tens, seg_min_units};

    always #(CLK_PERIOD / 2) CLK_60s = ~CLK_60s;

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic int random_time();
        int hours;
        int mins;
        hours = random_bits(5) % 24;
        mins  = random_bits(6) % 60;
        return hours * 60 + mins;
    endfunction

    // one cycle held, one cycle released
    task automatic press_key(input int idx);
        @(negedge CLK_60s);
        press_cycle = cycle;
        btn = keypad_t'(1) << idx;
        @(negedge CLK_60s);
        btn = '0;
    endtask

    task automatic type_time(input int m);
        int d [4];
        int shown [4];
        d[0] = (m / 60) / 10;
        d[1] = (m / 60) % 10;
        d[2] = (m % 60) / 10;
        d[3] = (m % 60) % 10;
        for (int i = 0; i < 4; i++)
            shown[i] = 15;             // untyped digits are blank
        for (int i = 0; i < 4; i++) begin
            press_key(d[i]);
            shown[i] = d[i];
            check_value(32'(seg_all), 32'(digits_to_segs(shown[0], shown[1], shown[2], shown[3])),
                        "entry display");
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("test %0d %s: passed", tests_run, name);
        else
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_before);
    endtask

    // model time steps on every rising edge, compared a quarter period later
    always begin
        bit exp_alarm;
        bit exp_timer;
        @(posedge CLK_60s);
        cycle++;
        exp_alarm = reset && alarm_valid_model && (model_minutes == alarm_minutes);
        if (!reset) begin
            model_minutes     = START_MINUTES;
            alarm_valid_model = 1'b0;
        end else begin
            if (cycle == time_load_edge)
                model_minutes = time_load_value;
            else
                model_minutes = minute_step(model_minutes);
            if (cycle == alarm_load_edge) begin
                alarm_minutes     = alarm_load_value;
                alarm_valid_model = 1'b1;
            end
        end
        exp_timer = (cycle == timer_done_edge);
        #(CLK_PERIOD / 4);
        if (time_shown)
            check_value(32'(seg_all), 32'(minutes_to_segs(model_minutes)), "time display");
        check_value(32'(beep_alarm), 32'(exp_alarm), "beep_alarm");
        check_value(32'(beep_timer), 32'(exp_timer), "beep_timer");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK_60s);
        $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int errors_before;
        int new_time;
        int alarm_at;
        int wait_count;
        reset            = 1'b0;
        btn              = '0;
        lfsr_state       = 32'h5c10;
        time_shown       = 1'b1;
        press_cycle      = 0;
        time_load_edge   = -1;
        time_load_value  = 0;
        alarm_load_edge  = -1;
        alarm_load_value = 0;
        timer_done_edge  = -1;

        errors_before = errors;
        repeat (RESET_CYCLES) @(posedge CLK_60s);
        @(negedge CLK_60s);
        check_value(32'(seg_all), 32'(digits_to_segs(1, 1, 5, 0)), "time after reset");
        reset = 1'b1;
        repeat (WRAP_CYCLES - 1) @(negedge CLK_60s);
        check_value(32'(seg_all), 32'(digits_to_segs(2, 3, 5, 9)), "time before midnight");
        @(negedge CLK_60s);
        check_value(32'(seg_all), 32'(digits_to_segs(0, 0, 0, 0)), "time at midnight");
        report_test("time count and wrap", errors_before);

        errors_before = errors;
        time_shown = 1'b0;
        type_time(12 * 60 + 34);
        repeat (ENTRY_HOLD - 1) @(negedge CLK_60s);
        check_value(32'(seg_all), 32'(digits_to_segs(1, 2, 3, 4)), "entry still held");
        @(negedge CLK_60s);
        check_value(32'(seg_all), 32'(minutes_to_segs(model_minutes)), "time after entry timeout");
        time_shown = 1'b1;
        repeat (4) @(negedge CLK_60s);
        report_test("entry display and timeout", errors_before);

        errors_before = errors;
        new_time = random_time();
        time_shown = 1'b0;
        type_time(new_time);
        press_key(KEY_TIME_SET);
        time_load_value = new_time;
        time_load_edge  = press_cycle + 2;    // strobe at the next edge, load one later
        time_shown = 1'b1;
        @(negedge CLK_60s);
        check_value(32'(seg_all), 32'(minutes_to_segs(new_time)), "time after time set");
        repeat (20) @(negedge CLK_60s);
        report_test("time set", errors_before);

        errors_before = errors;
        alarm_at = (model_minutes + 20 + random_bits(4)) % DAY_MINUTES;
        time_shown = 1'b0;
        type_time(alarm_at);
        press_key(KEY_ALARM);
        alarm_load_value = alarm_at;
        alarm_load_edge  = press_cycle + 2;
        time_shown = 1'b1;
        @(negedge CLK_60s);
        time_shown = 1'b0;
        btn = keypad_t'(1) << KEY_ALARM;      // hold with no entry pending
        @(negedge CLK_60s);
        check_value(32'(seg_all), 32'(minutes_to_segs(alarm_at)), "alarm display");
        btn = '0;
        time_shown = 1'b1;
        wait_count = 0;
        while (beep_alarm !== 1'b1 && wait_count < ALARM_WAIT) begin
            @(negedge CLK_60s);
            wait_count++;
        end
        if (beep_alarm !== 1'b1) begin
            errors++;
            $display("the alarm did not sound within %0d cycles of the expected time", ALARM_WAIT);
        end else begin
            check_value(32'(model_minutes), 32'((alarm_at + 1) % DAY_MINUTES),
                        "time when the alarm sounds");
        end
        repeat (3) @(negedge CLK_60s);
        report_test("alarm", errors_before);

        errors_before = errors;
        time_shown = 1'b0;
        type_time(TIMER_MINUTES);
        press_key(KEY_TIMER);
        timer_done_edge = press_cycle + 2 + TIMER_MINUTES;   // loaded, then one per edge
        do begin
            @(negedge CLK_60s);
            check_value(32'(seg_all), 32'(minutes_to_segs(timer_done_edge - cycle)),
                        "timer display");
        end while (cycle < timer_done_edge);
        @(negedge CLK_60s);
        check_value(32'(seg_all), 32'(minutes_to_segs(model_minutes)), "time after countdown");
        time_shown = 1'b1;
        repeat (4) @(negedge CLK_60s);
        report_test("countdown", errors_before);

        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+bench
verilog/clock_pkg.sv
verilog/timekeeper.sv
verilog/keypad_control.sv
verilog/countdown_timer.sv
verilog/display_driver.sv
verilog/alarm_clock_top.sv
bench/alarm_clock_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the alarm clock testbench with Verilator, run it and judge the log
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module alarm_clock_tb \
    -f sources.f

./obj_dir/Valarm_clock_tb | tee sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
